//--- src/range_stream_pkg.sv
package range_stream_pkg;

   // descriptor fields
   localparam int W_BASE = 16;       // first element of a series
   localparam int W_INCR = 16;       // step between elements
   localparam int W_CNT  = 16;       // elements per series, also the result length

   // element stream
   // elements wrap modulo 2^W_ELEM, so base + i*incr never grows past this width
   localparam int W_ELEM = 16;

   // result of one series
   localparam int W_SUM  = 24;       // running sum wraps modulo 2^W_SUM

   // elastic buffer between generator and reducer
   localparam int FIFO_DEPTH = 4;

   // pointer into the buffer storage
   localparam int W_FIFO_PTR = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

   // occupancy must also hold the value FIFO_DEPTH itself
   localparam int W_FIFO_OCC = $clog2(FIFO_DEPTH + 1);

endpackage

//--- src/range_gen.sv
module range_gen (
   input  logic                                clk,
   input  logic                                arst_n,

   // descriptor in
   input  logic                                desc_valid,
   input  logic [range_stream_pkg::W_BASE-1:0] desc_base,
   input  logic [range_stream_pkg::W_INCR-1:0] desc_incr,
   input  logic [range_stream_pkg::W_CNT-1:0]  desc_cnt,
   output logic                                desc_ready,

   // element stream out
   output logic                                gen_valid,
   output logic                                gen_eot,
   output logic [range_stream_pkg::W_ELEM-1:0] gen_elem,
   input  logic                                gen_ready
);

   logic [range_stream_pkg::W_CNT-1:0]  idx_q;     // index of the element on the output
   logic [range_stream_pkg::W_CNT-1:0]  idx_next;
   logic [range_stream_pkg::W_ELEM-1:0] step_off;  // idx * incr, wrapped to element width
   logic                                handshake;
   logic                                last_elem;

   // the generator has no state of its own beyond the index,
   // so the element stream is valid exactly when a descriptor is offered
   assign gen_valid = desc_valid;
   assign handshake = desc_valid & gen_ready;

   assign idx_next  = idx_q + 1'b1;
   assign last_elem = (idx_next == desc_cnt);

   // multiplied increment, counting in steps of one
   assign step_off = range_stream_pkg::W_ELEM'(idx_q * desc_incr);
   assign gen_elem = range_stream_pkg::W_ELEM'(desc_base) + step_off;
   assign gen_eot  = last_elem;

   // descriptor is released together with its last element
   assign desc_ready = last_elem & handshake;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         idx_q <= '0;
      end else if (handshake) begin
         if (last_elem) begin
            idx_q <= '0;                      // ready for the next descriptor
         end else begin
            idx_q <= idx_next;
         end
      end
   end

   // a zero count would run the index through the whole counter range
   a_cnt_nonzero : assert property (
      @(posedge clk) disable iff (!arst_n)
      desc_valid |-> (desc_cnt != '0)
   ) else $error("range_gen: descriptor with zero count");

   // the elements are computed from the live descriptor, so it must
   // be held unchanged until its last element has been taken
   a_desc_stable : assert property (
      @(posedge clk) disable iff (!arst_n)
      (desc_valid && !desc_ready) |=>
         (desc_valid && $stable(desc_base) && $stable(desc_incr) && $stable(desc_cnt))
   ) else $error("range_gen: descriptor changed while pending");

endmodule

//--- src/elem_fifo.sv
module elem_fifo (
   input  logic                                clk,
   input  logic                                arst_n,

   // write side
   input  logic                                wr_valid,
   input  logic                                wr_eot,
   input  logic [range_stream_pkg::W_ELEM-1:0] wr_elem,
   output logic                                wr_ready,

   // read side
   output logic                                rd_valid,
   output logic                                rd_eot,
   output logic [range_stream_pkg::W_ELEM-1:0] rd_elem,
   input  logic                                rd_ready
);

   localparam int DEPTH = range_stream_pkg::FIFO_DEPTH;
   localparam int W_PTR = range_stream_pkg::W_FIFO_PTR;
   localparam int W_OCC = range_stream_pkg::W_FIFO_OCC;

   logic [range_stream_pkg::W_ELEM-1:0] mem_elem [DEPTH];
   logic                                mem_eot  [DEPTH];

   logic [W_PTR-1:0] wr_ptr;
   logic [W_PTR-1:0] rd_ptr;
   logic [W_OCC-1:0] occ;
   logic             full;
   logic             wr_fire;
   logic             rd_fire;

   assign full     = (occ == W_OCC'(DEPTH));
   assign rd_valid = (occ != '0);

   // when full, a simultaneous read frees the slot being written
   assign wr_ready = ~full | rd_ready;

   assign wr_fire = wr_valid & wr_ready;
   assign rd_fire = rd_valid & rd_ready;

   assign rd_elem = mem_elem[rd_ptr];
   assign rd_eot  = mem_eot[rd_ptr];

   // storage
   always_ff @(posedge clk) begin
      if (wr_fire) begin
         mem_elem[wr_ptr] <= wr_elem;
         mem_eot[wr_ptr]  <= wr_eot;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         occ    <= '0;
      end else begin
         if (wr_fire) begin
            wr_ptr <= (wr_ptr == W_PTR'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_fire) begin
            rd_ptr <= (rd_ptr == W_PTR'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_fire, rd_fire})
            2'b10:   occ <= occ + 1'b1;
            2'b01:   occ <= occ - 1'b1;
            default: occ <= occ;       // both or neither leaves the level unchanged
         endcase
      end
   end

   a_occ_bound : assert property (
      @(posedge clk) disable iff (!arst_n)
      occ <= W_OCC'(DEPTH)
   ) else $error("elem_fifo: occupancy above depth");

   // an empty or a full buffer has both pointers on the same slot
   a_ptr_agree : assert property (
      @(posedge clk) disable iff (!arst_n)
      (occ == '0 || occ == W_OCC'(DEPTH)) |-> (wr_ptr == rd_ptr)
   ) else $error("elem_fifo: pointers disagree with occupancy");

endmodule

//--- src/range_reduce.sv
module range_reduce (
   input  logic                                clk,
   input  logic                                arst_n,

   // element stream in
   input  logic                                in_valid,
   input  logic                                in_eot,
   input  logic [range_stream_pkg::W_ELEM-1:0] in_elem,
   output logic                                in_ready,

   // one result per series
   output logic                                res_valid,
   output logic [range_stream_pkg::W_SUM-1:0]  res_sum,
   output logic [range_stream_pkg::W_CNT-1:0]  res_len,
   input  logic                                res_ready
);

   logic [range_stream_pkg::W_SUM-1:0] acc_sum;   // partial sum of the open series
   logic [range_stream_pkg::W_CNT-1:0] acc_len;
   logic [range_stream_pkg::W_SUM-1:0] sum_next;
   logic [range_stream_pkg::W_CNT-1:0] len_next;
   logic                               in_fire;
   logic                               close_fire;  // eot element accepted

   // only an eot element needs the result register, so only it waits
   // for the previous result to leave
   assign in_ready = ~(in_eot & res_valid & ~res_ready);

   assign in_fire    = in_valid & in_ready;
   assign close_fire = in_fire & in_eot;

   assign sum_next = acc_sum + range_stream_pkg::W_SUM'(in_elem);
   assign len_next = acc_len + 1'b1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         acc_sum   <= '0;
         acc_len   <= '0;
         res_valid <= 1'b0;
      end else begin
         if (close_fire) begin
            acc_sum <= '0;                  // next series starts fresh
            acc_len <= '0;
         end else if (in_fire) begin
            acc_sum <= sum_next;
            acc_len <= len_next;
         end

         // a new result may replace one that is taken in the same cycle
         if (close_fire) begin
            res_valid <= 1'b1;
         end else if (res_ready) begin
            res_valid <= 1'b0;
         end
      end
   end

   // result payload, loaded with the eot element included
   always_ff @(posedge clk) begin
      if (close_fire) begin
         res_sum <= sum_next;
         res_len <= len_next;
      end
   end

   a_res_hold : assert property (
      @(posedge clk) disable iff (!arst_n)
      (res_valid && !res_ready) |=> (res_valid && $stable(res_sum) && $stable(res_len))
   ) else $error("range_reduce: result changed before it was taken");

endmodule

//--- src/range_stream.sv
module range_stream (
   input  logic                                clk,
   input  logic                                arst_n,

   // descriptors
   input  logic                                desc_valid,
   input  logic [range_stream_pkg::W_BASE-1:0] desc_base,
   input  logic [range_stream_pkg::W_INCR-1:0] desc_incr,
   input  logic [range_stream_pkg::W_CNT-1:0]  desc_cnt,
   output logic                                desc_ready,

   // results
   output logic                                res_valid,
   output logic [range_stream_pkg::W_SUM-1:0]  res_sum,
   output logic [range_stream_pkg::W_CNT-1:0]  res_len,
   input  logic                                res_ready
);

   // generator to buffer
   logic                                gen_valid;
   logic                                gen_ready;
   logic                                gen_eot;
   logic [range_stream_pkg::W_ELEM-1:0] gen_elem;

   // buffer to reducer
   logic                                buf_valid;
   logic                                buf_ready;
   logic                                buf_eot;
   logic [range_stream_pkg::W_ELEM-1:0] buf_elem;

   range_gen u_gen (
      .clk        (clk),
      .arst_n     (arst_n),
      .desc_valid (desc_valid),
      .desc_base  (desc_base),
      .desc_incr  (desc_incr),
      .desc_cnt   (desc_cnt),
      .desc_ready (desc_ready),
      .gen_valid  (gen_valid),
      .gen_eot    (gen_eot),
      .gen_elem   (gen_elem),
      .gen_ready  (gen_ready)
   );

   // decouples the element stream from result back-pressure
   elem_fifo u_fifo (
      .clk      (clk),
      .arst_n   (arst_n),
      .wr_valid (gen_valid),
      .wr_eot   (gen_eot),
      .wr_elem  (gen_elem),
      .wr_ready (gen_ready),
      .rd_valid (buf_valid),
      .rd_eot   (buf_eot),
      .rd_elem  (buf_elem),
      .rd_ready (buf_ready)
   );

   range_reduce u_reduce (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (buf_valid),
      .in_eot    (buf_eot),
      .in_elem   (buf_elem),
      .in_ready  (buf_ready),
      .res_valid (res_valid),
      .res_sum   (res_sum),
      .res_len   (res_len),
      .res_ready (res_ready)
   );

endmodule

//--- tb/range_stream_tb_util.svh
`ifndef RANGE_STREAM_TB_UTIL_SVH
`define RANGE_STREAM_TB_UTIL_SVH

// 16-bit Galois LFSR, taps 16,14,13,11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
   if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
   end else begin
      return state >> 1;
   end
endfunction

// one LFSR step per bit taken
task automatic rand_bits(inout logic [15:0] state, input int n, output logic [31:0] value);
   int k;
   value = '0;
   for (k = 0; k < n; k++) begin
      value = {value[30:0], state[0]};
      state = lfsr_step(state);
   end
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
   check_count++;
   if (got !== exp) begin
      $display("mismatch at time %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      err_count++;
   end
endtask

// returns right after the rising edge that consumed the descriptor
task automatic wait_desc_accept();
   int  cycles;
   bit  done;
   cycles = 0;
   done   = 1'b0;
   while (!done && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (desc_valid && desc_ready) begin
         done = 1'b1;
      end
   end
   if (!done) begin
      $display("descriptor not accepted within %0d cycles", TIMEOUT);
      err_count++;
   end
endtask

// waits until every expected result has been seen, then realigns to a rising edge
task automatic wait_drain();
   int  cycles;
   cycles = 0;
   while (exp_sum_q.size() != 0 && cycles < TIMEOUT) begin
      @(negedge clk);          // queue is settled away from the sampling edge
      cycles++;
   end
   if (exp_sum_q.size() != 0) begin
      $display("no result within %0d cycles", TIMEOUT);
      err_count++;
   end
   @(posedge clk);
endtask

`endif

//--- tb/range_stream_tb.sv
module range_stream_tb;

   localparam int TIMEOUT = 2000;   // cycles per wait

   logic                                clk;
   logic                                arst_n;
   logic                                desc_valid;
   logic [range_stream_pkg::W_BASE-1:0] desc_base;
   logic [range_stream_pkg::W_INCR-1:0] desc_incr;
   logic [range_stream_pkg::W_CNT-1:0]  desc_cnt;
   logic                                desc_ready;
   logic                                res_valid;
   logic [range_stream_pkg::W_SUM-1:0]  res_sum;
   logic [range_stream_pkg::W_CNT-1:0]  res_len;
   logic                                res_ready;

   logic [15:0] stim_lfsr;          // descriptor fields
   logic [15:0] ready_lfsr;         // res_ready pattern
   logic        rand_ready_en;
   int          err_count;
   int          check_count;
   int          desc_count;
   int          res_count;
   int          test_count;
   int          test_err_base;

   // expected results with the oldest first
   logic [range_stream_pkg::W_SUM-1:0] exp_sum_q [$];
   logic [range_stream_pkg::W_CNT-1:0] exp_len_q [$];

   `include "range_stream_tb_util.svh"

   range_stream u_dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .desc_valid (desc_valid),
      .desc_base  (desc_base),
      .desc_incr  (desc_incr),
      .desc_cnt   (desc_cnt),
      .desc_ready (desc_ready),
      .res_valid  (res_valid),
      .res_sum    (res_sum),
      .res_len    (res_len),
      .res_ready  (res_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // reference model that walks the series by repeated addition
   function automatic logic [range_stream_pkg::W_SUM-1:0] series_sum(
      input logic [15:0] base, input logic [15:0] incr, input logic [15:0] cnt);
      logic [range_stream_pkg::W_ELEM-1:0] elem;
      logic [range_stream_pkg::W_SUM-1:0]  sum;
      int                                  i;
      elem = base;
      sum  = '0;
      for (i = 0; i < cnt; i++) begin
         sum  = sum + range_stream_pkg::W_SUM'(elem);
         elem = elem + incr;                  // wraps at element width
      end
      return sum;
   endfunction

   // called right after a rising edge
   task automatic drive_desc(input logic [15:0] base, input logic [15:0] incr,
                             input logic [15:0] cnt);
      #1;
      desc_valid = 1'b1;
      desc_base  = base;
      desc_incr  = incr;
      desc_cnt   = cnt;
      exp_sum_q.push_back(series_sum(base, incr, cnt));
      exp_len_q.push_back(cnt);
      desc_count++;
      wait_desc_accept();
   endtask

   task automatic idle_desc();
      #1 desc_valid = 1'b0;
   endtask

   task automatic send_random(input int max_cnt);
      logic [31:0] b;
      logic [31:0] inc;
      logic [31:0] c;
      rand_bits(stim_lfsr, 16, b);
      rand_bits(stim_lfsr, 16, inc);
      rand_bits(stim_lfsr, 5, c);
      drive_desc(b[15:0], inc[15:0], 16'(c % max_cnt + 1));
   endtask

   task automatic end_test(input string name);
      test_count++;
      $display("test %0d %s %s (%0d errors)", test_count, name,
               (err_count == test_err_base) ? "ok" : "failed", err_count - test_err_base);
      test_err_base = err_count;
   endtask

   // res_ready with random stalls of up to 30 cycles when enabled
   initial begin
      int          low_left;
      logic [31:0] r;
      low_left   = 0;
      ready_lfsr = 16'd10;
      res_ready  = 1'b1;
      forever begin
         @(posedge clk);
         #1;
         if (!rand_ready_en) begin
            res_ready = 1'b1;
            low_left  = 0;
         end else begin
            if (low_left == 0) begin
               rand_bits(ready_lfsr, 2, r);
               if (r == 0) begin
                  rand_bits(ready_lfsr, 5, r);
                  low_left = int'(r % 30) + 1;
               end
            end
            if (low_left > 0) begin
               res_ready = 1'b0;
               low_left--;
            end else begin
               res_ready = 1'b1;
            end
         end
      end
   end

   // scoreboard
   initial begin
      logic [range_stream_pkg::W_SUM-1:0] exp_sum;
      logic [range_stream_pkg::W_CNT-1:0] exp_len;
      forever begin
         @(posedge clk);
         if (arst_n && res_valid && res_ready) begin
            res_count++;
            if (exp_sum_q.size() == 0) begin
               $display("result at time %0t arrived with no descriptor outstanding", $time);
               err_count++;
            end else begin
               exp_sum = exp_sum_q.pop_front();
               exp_len = exp_len_q.pop_front();
               check_value(32'(res_sum), 32'(exp_sum), "result sum");
               check_value(32'(res_len), 32'(exp_len), "result length");
            end
         end
      end
   end

   initial begin
      logic [31:0] b;
      logic [31:0] inc;
      logic [31:0] c;
      arst_n        = 1'b0;
      desc_valid    = 1'b0;
      desc_base     = '0;
      desc_incr     = '0;
      desc_cnt      = '0;
      rand_ready_en = 1'b0;
      stim_lfsr     = 16'd10;
      err_count     = 0;
      check_count   = 0;
      desc_count    = 0;
      res_count     = 0;
      test_count    = 0;
      test_err_base = 0;

      repeat (16) @(posedge clk);
      #1 arst_n = 1'b1;
      @(posedge clk);

      check_value(32'(res_valid), 32'd0, "res_valid after reset");
      check_value(32'(desc_ready), 32'd0, "desc_ready after reset");
      end_test("reset");

      repeat (10) begin
         send_random(20);
         idle_desc();
         wait_drain();
      end
      end_test("single");

      repeat (20) send_random(8);       // no gap between descriptors
      idle_desc();
      wait_drain();
      end_test("back_to_back");

      rand_ready_en = 1'b1;
      repeat (15) send_random(20);
      idle_desc();
      wait_drain();
      rand_ready_en = 1'b0;
      end_test("backpressure");

      repeat (8) begin
         rand_bits(stim_lfsr, 16, b);
         rand_bits(stim_lfsr, 16, inc);
         drive_desc(b[15:0], inc[15:0], 16'd1);
      end
      idle_desc();
      wait_drain();
      end_test("count_one");

      // high base and increment over enough elements to wrap the sum
      repeat (4) begin
         rand_bits(stim_lfsr, 12, b);
         rand_bits(stim_lfsr, 14, inc);
         rand_bits(stim_lfsr, 8, c);
         drive_desc(16'hF000 | b[15:0], 16'hC000 | inc[15:0], 16'd768 + c[15:0]);
      end
      idle_desc();
      wait_drain();
      end_test("wrap");

      check_value(32'(res_count), 32'(desc_count), "number of results");

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- range_stream.f
+incdir+tb
src/range_stream_pkg.sv
src/range_gen.sv
src/elem_fifo.sv
src/range_reduce.sv
src/range_stream.sv
tb/range_stream_tb.sv

//--- Bender.yml
package:
  name: range_stream

sources:
  - src/range_stream_pkg.sv
  - src/range_gen.sv
  - src/elem_fifo.sv
  - src/range_reduce.sv
  - src/range_stream.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/range_stream_tb.sv
